/* Bender.yml */
package:
  name: uart_cmd

sources:
  - files:
      - rtl/uart_cmd_pkg.sv
      - rtl/uart_tx_frame.sv
      - rtl/uart_rx_frame.sv
      - rtl/uart_cmd_ctrl.sv
      - rtl/uart_cmd_top.sv
  - target: test
    files:
      - tests/uart_cmd_tb.sv

/* build.f */
rtl/uart_cmd_pkg.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_cmd_ctrl.sv
rtl/uart_cmd_top.sv
tests/uart_cmd_tb.sv

/* rtl/uart_cmd_ctrl.sv */
`timescale 1ns/1ps

module uart_cmd_ctrl
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [cmd_width-1:0]  cmd_in,
  input  logic                  cmd_vld,
  input  logic                  tx_done,
  input  logic                  rx_valid,
  input  logic [byte_width-1:0] rx_byte,
  input  logic                  rx_error,
  input  logic                  rx_busy,
  output logic                  cmd_rdy,
  output logic                  tx_start,
  output logic [byte_width-1:0] tx_byte,
  output logic                  rx_enable,
  output logic                  read_rdy,
  output logic [byte_width:0]   read_data
);

  typedef enum logic [2:0] {
    st_idle,
    st_send_hi,
    st_send_lo,
    st_wait_reply,
    st_finish
  } state_t;

  state_t                       state;
  logic [cmd_width-1:0]         cmd_q;
  logic [baud_cnt_width-1:0]    baud_cnt;
  logic [timeout_cnt_width-1:0] bit_times;
  logic                         accept;
  logic                         is_write;
  logic                         bit_end;
  logic                         timed_out;

  assign accept = cmd_vld && cmd_rdy;

  // bit 15 set means write, two frames
  assign is_write = cmd_q[cmd_width-1];

  assign tx_byte = (state == st_send_lo) ? cmd_q[byte_width-1:0]
                                         : cmd_q[cmd_width-1:byte_width];

  assign bit_end = (baud_cnt == baud_cnt_width'(clks_per_bit - 1));
  assign timed_out = !rx_busy && (bit_times == timeout_cnt_width'(reply_timeout_bits));

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  // reply timeout, paused while the receiver is busy with a frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
      bit_times <= '0;
    end else if (state != st_wait_reply) begin
      baud_cnt <= '0;
      bit_times <= '0;
    end else if (!rx_busy && !timed_out) begin
      if (bit_end) begin
        baud_cnt <= '0;
        bit_times <= bit_times + 1'b1;
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      cmd_rdy <= 1'b1;
      tx_start <= 1'b0;
      rx_enable <= 1'b0;
      read_rdy <= 1'b0;
      read_data <= '0;
    end else begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_send_hi;
            cmd_rdy <= 1'b0;
            tx_start <= 1'b1;
          end
        end
        st_send_hi: begin
          if (tx_done) begin
            if (is_write) begin
              state <= st_send_lo;
              tx_start <= 1'b1;
            end else begin
              state <= st_wait_reply;
              rx_enable <= 1'b1;
            end
          end
        end
        st_send_lo: begin
          if (tx_done) begin
            state <= st_idle;
            cmd_rdy <= 1'b1;
          end
        end
        st_wait_reply: begin
          if (rx_valid) begin
            read_data <= {rx_error, rx_byte};
            rx_enable <= 1'b0;
            state <= st_finish;
          end else if (timed_out) begin
            // no start bit seen, error with zero data
            read_data <= {1'b1, byte_width'(0)};
            rx_enable <= 1'b0;
            state <= st_finish;
          end
        end
        st_finish: begin
          read_rdy <= 1'b1;
          cmd_rdy <= 1'b1;
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  a_rdy_only_idle : assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> (state == st_idle)
  );

  a_read_rdy_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy
  );

endmodule

/* rtl/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // line timing
  localparam int clk_hz = 50_000_000;
  localparam int baud = 115_200;
  localparam int clks_per_bit = clk_hz / baud;
  localparam int half_bit = clks_per_bit / 2;

  // frame layout: start, 8 data, parity, stop
  localparam int frame_bits = 11;
  localparam int cmd_width = 16;
  localparam int byte_width = 8;

  // bit times to wait for a reply start bit
  localparam int reply_timeout_bits = 32;

  // counter widths
  localparam int baud_cnt_width = $clog2(clks_per_bit);
  localparam int frame_cnt_width = $clog2(frame_bits);
  localparam int timeout_cnt_width = $clog2(reply_timeout_bits + 1);

  // odd parity, ones in data plus parity bit add up to an odd count
  function automatic logic odd_parity(input logic [byte_width-1:0] data);
    return ~^data;
  endfunction

endpackage

/* rtl/uart_cmd_top.sv */
`timescale 1ns/1ps

module uart_cmd_top
  import uart_cmd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [cmd_width-1:0] cmd_in,
  input  logic                 cmd_vld,
  input  logic                 rx,
  output logic                 tx,
  output logic                 cmd_rdy,
  output logic                 read_rdy,
  // error flag on top of the reply byte
  output logic [byte_width:0]  read_data
);

  logic                  tx_start;
  logic                  tx_done;
  logic [byte_width-1:0] tx_byte;
  logic                  rx_enable;
  logic                  rx_busy;
  logic                  rx_valid;
  logic [byte_width-1:0] rx_byte;
  logic                  rx_error;

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .tx_done   (tx_done),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_error  (rx_error),
    .rx_busy   (rx_busy),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .rx_enable (rx_enable),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_frame u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_enable (rx_enable),
    .rx_busy   (rx_busy),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_error  (rx_error)
  );

endmodule

/* rtl/uart_rx_frame.sv */
`timescale 1ns/1ps

module uart_rx_frame
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx,
  input  logic                  rx_enable,
  output logic                  rx_busy,
  output logic                  rx_valid,
  output logic [byte_width-1:0] rx_byte,
  output logic                  rx_error
);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_bits,
    rx_stop
  } rx_state_t;

  rx_state_t                  state;
  logic                       rx_meta;
  logic                       rx_sync;
  logic                       rx_prev;
  logic [baud_cnt_width-1:0]  baud_cnt;
  logic [frame_cnt_width-1:0] bit_idx;
  // data, then parity, then stop at the top
  logic [byte_width+1:0]      frame_sr;
  logic                       fall_edge;
  logic                       start_det;
  logic                       half_end;
  logic                       bit_end;

  assign fall_edge = rx_prev && !rx_sync;
  assign start_det = (state == rx_idle) && rx_enable && fall_edge;
  assign half_end = (baud_cnt == baud_cnt_width'(half_bit - 1));
  assign bit_end = (baud_cnt == baud_cnt_width'(clks_per_bit - 1));

  assign rx_busy = (state != rx_idle);
  assign rx_valid = (state == rx_stop) && half_end;
  assign rx_byte = frame_sr[byte_width-1:0];
  assign rx_error = (frame_sr[byte_width] != odd_parity(frame_sr[byte_width-1:0]))
                    || !frame_sr[byte_width+1];

  // two flop synchronizer plus edge history
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= rx_idle;
      baud_cnt <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        rx_idle: begin
          baud_cnt <= '0;
          bit_idx <= '0;
          if (start_det) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          if (half_end) begin
            baud_cnt <= '0;
            // line back high at mid start bit is a glitch
            state <= rx_sync ? rx_idle : rx_bits;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_bits: begin
          if (bit_end) begin
            baud_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == frame_cnt_width'(frame_bits - 2)) begin
              state <= rx_stop;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_stop: begin
          // hold off half a bit past the stop sample
          if (half_end) begin
            baud_cnt <= '0;
            state <= rx_idle;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin
          state <= rx_idle;
        end
      endcase
    end
  end

  // mid-bit samples shift in LSB first
  always_ff @(posedge clk) begin
    if ((state == rx_bits) && bit_end) begin
      frame_sr <= {rx_sync, frame_sr[byte_width+1:1]};
    end
  end

  // a line edge in the rx_valid cycle would be missed on the way back to idle
  a_valid_not_with_start : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(rx_valid && fall_edge)
  );

endmodule

/* rtl/uart_tx_frame.sv */
`timescale 1ns/1ps

module uart_tx_frame
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  tx_start,
  input  logic [byte_width-1:0] tx_byte,
  output logic                  tx,
  output logic                  tx_done
);

  logic [frame_bits-1:0]      frame_sr;
  logic [baud_cnt_width-1:0]  baud_cnt;
  logic [frame_cnt_width-1:0] bit_idx;
  logic                       busy;
  logic                       bit_end;

  assign bit_end = busy && (baud_cnt == baud_cnt_width'(clks_per_bit - 1));

  // last cycle of the stop bit
  assign tx_done = bit_end && (bit_idx == frame_cnt_width'(frame_bits - 1));

  assign tx = frame_sr[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (tx_start) begin
      busy <= 1'b1;
    end else if (tx_done) begin
      busy <= 1'b0;
    end
  end

  // bit period counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
    end else if (tx_start || bit_end) begin
      baud_cnt <= '0;
    end else if (busy) begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_idx <= '0;
    end else if (tx_start) begin
      bit_idx <= '0;
    end else if (bit_end) begin
      if (tx_done) begin
        bit_idx <= '0;
      end else begin
        bit_idx <= bit_idx + 1'b1;
      end
    end
  end

  // ones shift in behind the frame so the line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_sr <= '1;
    end else if (tx_start) begin
      frame_sr <= {1'b1, odd_parity(tx_byte), tx_byte, 1'b0};
    end else if (bit_end) begin
      frame_sr <= {1'b1, frame_sr[frame_bits-1:1]};
    end
  end

  // controller must wait for tx_done before the next frame
  a_no_start_when_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    busy |-> !tx_start
  );

  a_idle_line_high : assert property (
    @(posedge clk) disable iff (!rst_n)
    !busy |-> tx
  );

endmodule

/* tests/uart_cmd_tb.sv */
`timescale 1ns/1ps

module uart_cmd_tb
  import uart_cmd_pkg::*;
();

  localparam int num_cmds = 40;
  localparam int frame_clks = frame_bits * clks_per_bit;
  localparam int mode_write = 0;
  localparam int mode_clean = 1;
  localparam int mode_parity = 2;
  localparam int mode_silent = 3;
  localparam int mode_glitch = 4;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic [cmd_width-1:0] cmd_in;
  logic                 cmd_vld;
  logic                 rx;
  logic                 tx;
  logic                 cmd_rdy;
  logic                 read_rdy;
  logic [byte_width:0]  read_data;

  logic [31:0] lfsr_state = 32'h3a66e502;
  logic [7:0]  dev_mem [128];
  logic [7:0]  frames_q [$];
  int          cycle_cnt = 0;
  int          hdr_end_cycle = 0;
  int          rdy_pulses = 0;
  int          reply_mode = 0;
  int          reply_delay = 1;
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  always @(negedge clk) begin
    if (read_rdy) begin
      rdy_pulses = rdy_pulses + 1;
    end
  end

  uart_cmd_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic next_rand_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], next_rand_bit()};
    end
    return r;
  endfunction

  function automatic int count_ones(input logic [15:0] v);
    int n;
    n = 0;
    for (int i = 0; i < 16; i++) begin
      n += v[i];
    end
    return n;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // random traffic on the command port while busy
  task automatic drive_junk();
    cmd_vld = next_rand_bit();
    if (cmd_vld) begin
      cmd_in = 16'(rand_bits(16));
    end
  endtask

  task automatic wait_done(input logic is_read, output logic ok);
    int   limit;
    int   n;
    logic early_rdy;
    limit = 3 * frame_clks;
    if (is_read) begin
      limit += (reply_timeout_bits + 8) * clks_per_bit;
    end
    n = 0;
    ok = 1'b0;
    early_rdy = 1'b0;
    while (!ok && n < limit) begin
      @(negedge clk);
      ok = is_read ? read_rdy : cmd_rdy;
      if (ok) begin
        cmd_vld = 1'b0;
      end else begin
        early_rdy |= cmd_rdy;
        drive_junk();
      end
      n++;
    end
    if (!ok) begin
      timeouts++;
      $display("timeout: command did not complete within %0d cycles", limit);
    end else if (is_read) begin
      check_eq(cmd_rdy, 1, "cmd_rdy with read_rdy");
      check_eq(early_rdy, 0, "cmd_rdy before read_rdy");
    end
  endtask

  task automatic wait_tx_low(output logic found);
    int n;
    n = 0;
    found = 1'b0;
    while (!found && n < 4 * frame_clks) begin
      @(negedge clk);
      found = (tx === 1'b0);
      n++;
    end
  endtask

  // called one half cycle into the start bit
  task automatic receive_frame(output logic [7:0] data);
    logic [10:0] bits;
    repeat (half_bit) @(negedge clk);
    bits[0] = tx;
    for (int i = 1; i < frame_bits; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      bits[i] = tx;
    end
    data = bits[8:1];
    check_eq(bits[0], 0, "tx start bit");
    check_eq(bits[10], 1, "tx stop bit");
    check_eq(count_ones(16'(bits[9:1])) % 2, 1, "tx odd parity");
  endtask

  task automatic send_frame(input logic [7:0] data, input logic flip);
    logic [9:0] bits;
    bits = {(count_ones(16'(data)) % 2 == 0) ^ flip, data, 1'b0};
    for (int i = 0; i < frame_bits - 1; i++) begin
      rx = bits[i];
      repeat (clks_per_bit) @(negedge clk);
    end
    // stop bit, line just stays high afterwards
    rx = 1'b1;
    repeat (half_bit) @(negedge clk);
  endtask

  task automatic send_reply(input logic [6:0] addr);
    repeat (reply_delay * clks_per_bit) @(negedge clk);
    if (reply_mode == mode_glitch) begin
      rx = 1'b0;
      repeat (clks_per_bit / 4) @(negedge clk);
      rx = 1'b1;
      repeat (clks_per_bit) @(negedge clk);
    end
    if (reply_mode != mode_silent) begin
      send_frame(dev_mem[addr], reply_mode == mode_parity);
    end
  endtask

  // register device on the far end of the line
  initial begin : device_model
    logic [7:0] frame;
    logic       found;
    logic       want_data;
    logic [6:0] wr_addr;
    for (int a = 0; a < 128; a++) begin
      dev_mem[a] = 8'((a * 37) ^ 8'h5c);
    end
    want_data = 1'b0;
    wr_addr = '0;
    forever begin
      wait_tx_low(found);
      if (found) begin
        receive_frame(frame);
        frames_q.push_back(frame);
        if (want_data) begin
          dev_mem[wr_addr] = frame;
          want_data = 1'b0;
        end else if (frame[7]) begin
          wr_addr = frame[6:0];
          want_data = 1'b1;
        end else begin
          hdr_end_cycle = cycle_cnt + clks_per_bit - half_bit;
          send_reply(frame[6:0]);
        end
      end
    end
  end

  initial begin : stimulus
    logic [cmd_width-1:0] cmd;
    logic [6:0]           addr;
    logic                 ok;
    int                   kind;
    int                   r;
    int                   done_cycle;
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_eq(tx, 1, "tx after reset");
    check_eq(cmd_rdy, 1, "cmd_rdy after reset");
    check_eq(read_rdy, 0, "read_rdy after reset");
    check_eq(read_data, 0, "read_data after reset");
    ok = 1'b1;
    for (int i = 0; i < num_cmds && ok; i++) begin
      // first five cover each case once
      if (i < 5) begin
        kind = i;
      end else begin
        r = rand_bits(3);
        kind = (r < 3) ? mode_write : (r < 5) ? mode_clean : r - 3;
      end
      addr = 7'(rand_bits(3)) | (next_rand_bit() ? 7'h70 : 7'h00);
      // bit 15 set selects a write
      cmd = {kind == mode_write, addr, 8'(rand_bits(8))};
      reply_mode = kind;
      reply_delay = 1 + rand_bits(2);
      frames_q.delete();
      rdy_pulses = 0;
      check_eq(cmd_rdy, 1, "cmd_rdy before command");
      cmd_in = cmd;
      cmd_vld = 1'b1;
      @(negedge clk);
      check_eq(cmd_rdy, 0, "cmd_rdy after accept");
      wait_done(kind != mode_write, ok);
      if (ok) begin
        done_cycle = cycle_cnt;
        @(negedge clk);
        check_eq(frames_q.size(), (kind == mode_write) ? 2 : 1, "frame count");
        if (frames_q.size() > 0) begin
          check_eq(frames_q[0], cmd[15:8], "high byte frame");
        end
        if (kind == mode_write) begin
          if (frames_q.size() > 1) begin
            check_eq(frames_q[1], cmd[7:0], "low byte frame");
          end
          check_eq(dev_mem[addr], cmd[7:0], "device memory after write");
          check_eq(rdy_pulses, 0, "read_rdy pulses on write");
        end else begin
          check_eq(rdy_pulses, 1, "read_rdy pulses on read");
          if (kind == mode_parity) begin
            check_eq(read_data[8], 1, "error flag on bad parity");
          end else if (kind == mode_silent) begin
            check_eq(read_data, 9'h100, "read_data on timeout");
            check_eq((done_cycle - hdr_end_cycle) <= (reply_timeout_bits + 2) * clks_per_bit,
                     1, "timeout latency");
          end else begin
            check_eq(read_data, {1'b0, dev_mem[addr]}, "read_data on clean reply");
          end
        end
        repeat (1 + rand_bits(4)) @(negedge clk);
      end
    end
    if (ok) begin
      // line must stay quiet with no command pending
      frames_q.delete();
      repeat (2 * frame_clks) @(negedge clk);
      check_eq(frames_q.size(), 0, "frames while idle");
      check_eq(tx, 1, "tx idle at end");
    end
    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
